// ==== Bender.yml ====
package:
  name: l1_axi_bridge

sources:
  - common/l1_axi_pkg.sv
  - logic/l1_req_arbiter.sv
  - axi_master/axi_txn_fsm.sv
  - logic/l1_axi_bridge.sv
  - target: test
    files:
      - dv/axi_slave_model.sv
      - dv/tb_l1_axi_bridge.sv

// ==== axi_master/axi_txn_fsm.sv ====
/* Single-beat AXI master, one transaction at a time, ID always 0. Writes present AW and W
   together; a slave stall is broken by the watchdog after 4096 cycles with a fault */
`timescale 1ns/1ps

module axi_txn_fsm import l1_axi_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    // Granted request
    input  l1_req_t  i_req,
    input  logic     i_req_valid,
    output logic     o_ready,
    // Response strobe, no back-pressure
    output l1_resp_t o_resp,
    output logic     o_resp_valid,
    // AXI master port
    output axi_m2s_t o_axi,
    input  axi_s2m_t i_axi
);

    txn_state_e state;
    txn_state_e state_nxt;

    logic [WDOG_BITS-1:0] wdog;
    logic                 wdog_to;

    logic accept;
    logic r_done;
    logic b_done;

    // Captured request fields
    logic [ADDR_BITS-1:0]  req_addr;
    logic [2:0]            req_size;
    logic [3:0]            req_cache;
    logic [2:0]            req_prot;
    logic [LINE_BITS-1:0]  req_wdata;
    logic [LINE_BYTES-1:0] req_wstrb;

    assign o_ready = (state == ST_IDLE);
    assign accept  = o_ready && i_req_valid;
    assign wdog_to = wdog[WDOG_BITS-1];

    // Single beat, so R last always comes with the only R valid
    assign r_done = (state == ST_R) && ((i_axi.r_valid && i_axi.r_last) || wdog_to);
    assign b_done = (state == ST_B) && (i_axi.b_valid || wdog_to);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (i_req_valid) begin
                    state_nxt = i_req.write ? ST_AW : ST_AR;
                end
            end
            ST_AR: begin
                if (i_axi.ar_ready || wdog_to) begin
                    state_nxt = ST_R;
                end
            end
            ST_R: begin
                if (r_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_AW: begin
                if (i_axi.aw_ready || wdog_to) begin
                    // W taken in the same cycle skips straight to B
                    state_nxt = i_axi.w_ready ? ST_B : ST_W;
                end
            end
            ST_W: begin
                if (i_axi.w_ready || wdog_to) begin
                    state_nxt = ST_B;
                end
            end
            ST_B: begin
                if (b_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_IDLE;
            wdog  <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE) begin
                wdog <= '0;
            end else begin
                wdog <= wdog + 1'b1;   // Counts every busy cycle
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_addr  <= i_req.addr;
            req_size  <= i_req.size;
            req_cache <= i_req.cached ? CACHE_WB_ALLOC : CACHE_DEVICE;
            // Instruction in bit 2, secure and unprivileged below
            req_prot  <= {i_req.path, 2'b00};
            if (i_req.write) begin
                req_wdata <= i_req.data;
                req_wstrb <= i_req.strb;
            end else begin
                req_wdata <= '0;
                req_wstrb <= '0;
            end
        end
    end

    // AXI channel drive, fields only meaningful while the matching valid is up
    always_comb begin
        o_axi          = '0;
        o_axi.ar.burst = BURST_INCR;
        o_axi.aw.burst = BURST_INCR;
        case (state)
            ST_AR: begin
                o_axi.ar_valid = 1'b1;
                o_axi.ar.addr  = req_addr;
                o_axi.ar.size  = req_size;
                o_axi.ar.cache = req_cache;
                o_axi.ar.prot  = req_prot;
            end
            ST_R: begin
                o_axi.r_ready = 1'b1;
            end
            ST_AW: begin
                o_axi.aw_valid = 1'b1;
                o_axi.aw.addr  = req_addr;
                o_axi.aw.size  = req_size;
                o_axi.aw.cache = req_cache;
                o_axi.aw.prot  = req_prot;
                o_axi.w_valid  = 1'b1;        // Lite-style, data with address
                o_axi.w_last   = 1'b1;
                o_axi.w_data   = req_wdata;
                o_axi.w_strb   = req_wstrb;
            end
            ST_W: begin
                o_axi.w_valid = 1'b1;
                o_axi.w_last  = 1'b1;
                o_axi.w_data  = req_wdata;
                o_axi.w_strb  = req_wstrb;
            end
            ST_B: begin
                o_axi.b_ready = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Response back toward the L1 side
    always_comb begin
        o_resp_valid       = r_done || b_done;
        o_resp.data        = i_axi.r_data;
        o_resp.load_fault  = r_done && (i_axi.r_resp[RESP_SLVERR_BIT] || wdog_to);
        o_resp.store_fault = b_done && (i_axi.b_resp[RESP_SLVERR_BIT] || wdog_to);
    end

    // AR must not drop or move before the slave takes it
    a_ar_hold: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_axi.ar_valid && !i_axi.ar_ready && !wdog_to)
            |=> (o_axi.ar_valid && $stable(o_axi.ar.addr))
    ) else $error("AR valid dropped or address changed before AR ready");

    a_one_channel: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        !(o_axi.ar_valid && o_axi.aw_valid)
    ) else $error("AR and AW issued together");

endmodule

// ==== common/l1_axi_pkg.sv ====
/* Single-beat AXI4 bridge types. AXI ID is fixed at zero and only one
   transaction is ever outstanding, so no ID matching is done anywhere */
package l1_axi_pkg;

    // Bus geometry
    localparam int ADDR_BITS   = 48;
    localparam int LINE_BITS   = 256;             // One L1 line per beat
    localparam int LINE_BYTES  = LINE_BITS / 8;   // 32 strobes
    localparam int AXI_ID_BITS = 1;

    // Stall watchdog, MSB set after 4096 busy cycles
    localparam int WDOG_BITS = 13;

    // AxCACHE codes
    localparam logic [3:0] CACHE_WB_ALLOC = 4'b1111;  // Write-back, read/write allocate
    localparam logic [3:0] CACHE_DEVICE   = 4'b0000;  // Device non-bufferable

    // Error flag inside RRESP/BRESP (SLVERR and DECERR both set it)
    localparam int RESP_SLVERR_BIT = 1;

    localparam logic [1:0] BURST_INCR = 2'b01;

    // Which L1 issued the request, also lands in AxPROT[2]
    typedef enum logic {
        L1_PATH_DATA  = 1'b0,
        L1_PATH_INSTR = 1'b1
    } l1_path_e;

    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_AR   = 3'd1,   // Read address out
        ST_R    = 3'd2,   // Waiting for read data
        ST_AW   = 3'd3,   // Write address and data out together
        ST_W    = 3'd4,   // Address taken, data still pending
        ST_B    = 3'd5    // Waiting for write response
    } txn_state_e;

    // Request from an L1 cache, path is overwritten by the arbiter
    typedef struct packed {
        l1_path_e               path;
        logic                   write;
        logic                   cached;
        logic [2:0]             size;    // AxSIZE encoding
        logic [ADDR_BITS-1:0]   addr;
        logic [LINE_BYTES-1:0]  strb;    // Ignored on reads
        logic [LINE_BITS-1:0]   data;    // Ignored on reads
    } l1_req_t;

    // Response strobe back to an L1 cache
    typedef struct packed {
        logic [LINE_BITS-1:0] data;      // Valid for reads only
        logic                 load_fault;
        logic                 store_fault;
    } l1_resp_t;

    // AR and AW share one field layout
    typedef struct packed {
        logic [AXI_ID_BITS-1:0] id;
        logic [ADDR_BITS-1:0]   addr;
        logic [2:0]             size;
        logic [1:0]             burst;
        logic [3:0]             cache;
        logic [2:0]             prot;
    } axi_ax_t;

    // Master to slave
    typedef struct packed {
        logic                  ar_valid;
        axi_ax_t               ar;
        logic                  aw_valid;
        axi_ax_t               aw;
        logic                  w_valid;
        logic                  w_last;
        logic [LINE_BITS-1:0]  w_data;
        logic [LINE_BYTES-1:0] w_strb;
        logic                  r_ready;
        logic                  b_ready;
    } axi_m2s_t;

    // Slave to master
    typedef struct packed {
        logic                 ar_ready;
        logic                 aw_ready;
        logic                 w_ready;
        logic                 r_valid;
        logic                 r_last;
        logic [LINE_BITS-1:0] r_data;
        logic [1:0]           r_resp;
        logic                 b_valid;
        logic [1:0]           b_resp;
    } axi_s2m_t;

endpackage

// ==== dv/axi_slave_model.sv ====
/* Behavioral single-beat AXI slave over 64 lines, picked by address bits 10:5.
   One transaction at a time; a write answered with SLVERR is not committed */
`timescale 1ns/1ps

module axi_slave_model import l1_axi_pkg::*; (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  axi_m2s_t   i_axi,
    output axi_s2m_t   o_axi,
    input  logic       i_force_err,   // SLVERR on R and B
    input  logic       i_stall_ar,    // Hold AR ready low
    input  logic [3:0] i_w_delay      // Cycles from AW to W ready, 0 takes both together
);

    logic [LINE_BITS-1:0] mem [64];
    logic [5:0]           rd_idx;
    logic [5:0]           wr_idx;
    logic [5:0]           w_idx;
    logic                 r_pend;
    logic                 b_pend;
    logic                 aw_seen;      // Address taken, data not yet
    logic [3:0]           w_wait;
    logic                 w_open;

    // Fill word follows the line index
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8{32'hc0de_0000 + i}};
        end
    end

    assign w_open = (i_w_delay == 4'd0) || (aw_seen && w_wait == 4'd0);
    assign w_idx  = aw_seen ? wr_idx : i_axi.aw.addr[10:5];

    always_comb begin
        o_axi          = '0;
        o_axi.ar_ready = i_axi.ar_valid && !i_stall_ar && !r_pend;
        o_axi.aw_ready = i_axi.aw_valid && !aw_seen && !b_pend;
        o_axi.w_ready  = i_axi.w_valid && w_open && !b_pend;
        o_axi.r_valid  = r_pend;
        o_axi.r_last   = r_pend;         // Single beat
        o_axi.r_data   = mem[rd_idx];
        o_axi.r_resp   = (r_pend && i_force_err) ? 2'b10 : 2'b00;
        o_axi.b_valid  = b_pend;
        o_axi.b_resp   = (b_pend && i_force_err) ? 2'b10 : 2'b00;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_pend  <= 1'b0;
            b_pend  <= 1'b0;
            aw_seen <= 1'b0;
            w_wait  <= '0;
            rd_idx  <= '0;
            wr_idx  <= '0;
        end else begin
            if (i_axi.ar_valid && o_axi.ar_ready) begin
                r_pend <= 1'b1;
                rd_idx <= i_axi.ar.addr[10:5];
            end else if (r_pend && i_axi.r_ready) begin
                r_pend <= 1'b0;
            end
            if (i_axi.aw_valid && o_axi.aw_ready && !o_axi.w_ready) begin
                aw_seen <= 1'b1;
                wr_idx  <= i_axi.aw.addr[10:5];
                w_wait  <= i_w_delay - 4'd1;
            end else if (aw_seen && w_wait != 4'd0) begin
                w_wait <= w_wait - 4'd1;
            end
            if (i_axi.w_valid && o_axi.w_ready) begin
                aw_seen <= 1'b0;
                b_pend  <= 1'b1;
            end else if (b_pend && i_axi.b_ready) begin
                b_pend <= 1'b0;
            end
        end
    end

    always @(posedge i_clk) begin
        if (i_axi.w_valid && o_axi.w_ready && !i_force_err) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (i_axi.w_strb[b]) begin
                    mem[w_idx][b*8 +: 8] <= i_axi.w_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== dv/tb_l1_axi_bridge.sv ====
/* Table-driven test of the L1 to AXI bridge against a behavioral slave. Port code 3
   sends a DC read and an IC read of the following line in the same cycle */
`timescale 1ns/1ps

module tb_l1_axi_bridge import l1_axi_pkg::*; ();

    typedef struct packed {
        logic [1:0]            port;       // 1 IC, 2 DC, 3 both
        logic                  wr;
        logic                  cached;
        logic [ADDR_BITS-1:0]  addr;
        logic [LINE_BYTES-1:0] strb;
        logic [LINE_BITS-1:0]  data;
        logic                  err;        // Slave controls
        logic                  stall_ar;
        logic [3:0]            w_delay;
        logic [LINE_BITS-1:0]  exp_data;   // DC line when port is 3
        logic [LINE_BITS-1:0]  exp_ic;
        logic [1:0]            exp_fault;  // {load, store}
    } entry_t;

    logic       i_clk;
    logic       i_nrst;
    l1_req_t    i_ic_req;
    logic       i_ic_req_valid;
    logic       o_ic_req_ready;
    l1_resp_t   o_ic_resp;
    logic       o_ic_resp_valid;
    l1_req_t    i_dc_req;
    logic       i_dc_req_valid;
    logic       o_dc_req_ready;
    l1_resp_t   o_dc_resp;
    logic       o_dc_resp_valid;
    axi_m2s_t   o_axi;
    axi_s2m_t   i_axi;
    logic       force_err;
    logic       stall_ar;
    logic [3:0] w_delay;

    entry_t               table_q[$];
    logic [LINE_BITS-1:0] ref_mem [64];   // Expected slave contents
    logic                 last_ic;        // IC was served last
    int                   errors;
    bit                   table_done = 1'b0;

    l1_axi_bridge UUT (.*);

    axi_slave_model u_slave (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_axi       (o_axi),
        .o_axi       (i_axi),
        .i_force_err (force_err),
        .i_stall_ar  (stall_ar),
        .i_w_delay   (w_delay)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic check_val(input int k, input string name, input logic [LINE_BITS-1:0] exp,
                             input logic [LINE_BITS-1:0] got);
        if (got !== exp) begin
            $display("[ERROR] test %0d: %s exp %0h got %0h", k, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_resp(input int k, input string name, input l1_resp_t r,
                              input logic [LINE_BITS-1:0] exp, input entry_t e);
        check_val(k, {name, ".load_fault"}, e.exp_fault[1], r.load_fault);
        check_val(k, {name, ".store_fault"}, e.exp_fault[0], r.store_fault);
        if (!e.wr && e.exp_fault == 2'b00) begin
            check_val(k, {name, ".data"}, exp, r.data);   // Faulted data is don't care
        end
    endtask

    // One entry, and the slave contents it leaves behind
    task automatic add_entry(input logic [1:0] port, input logic wr, input logic cached,
                             input logic [5:0] line, input logic err, input logic stall,
                             input logic [3:0] wdly);
        entry_t e;
        int     b;
        e = '{port: port, wr: wr, cached: cached, err: err, stall_ar: stall,
              w_delay: wdly, default: '0};
        e.addr       = {16'($urandom()), $urandom()};
        e.addr[10:0] = {line, 5'd0};             // Bits 10:5 select the slave line
        e.strb       = $urandom();
        for (b = 0; b < 8; b++) begin
            e.data[b*32 +: 32] = $urandom();
        end
        e.exp_data  = ref_mem[line];
        e.exp_ic    = ref_mem[line + 6'd1];
        e.exp_fault = {!wr && (err || stall), wr && err};
        for (b = 0; b < LINE_BYTES; b++) begin
            if (wr && !err && e.strb[b]) begin
                ref_mem[line][b*8 +: 8] = e.data[b*8 +: 8];
            end
        end
        table_q.push_back(e);
    endtask

    task automatic run_entry(input int k);
        entry_t     e;
        axi_ax_t    ax;
        logic [1:0] take;     // {IC, DC}, same order below
        logic [1:0] rv;
        logic [1:0] done;
        logic       first_ic;
        int         cyc;
        int         errs0;
        e        = table_q[k];
        errs0    = errors;
        done     = ~{e.port[0], e.port[1]};
        first_ic = 1'b0;
        ax       = '0;
        cyc      = 0;
        @(negedge i_clk);
        i_dc_req = '{path: L1_PATH_DATA, write: e.wr, cached: e.cached, size: 3'd5,
                     addr: e.addr, strb: e.strb, data: e.data};
        i_ic_req      = i_dc_req;
        i_ic_req.path = L1_PATH_INSTR;
        if (e.port == 2'd3) begin
            i_ic_req.addr = e.addr + LINE_BYTES;
        end
        i_ic_req_valid = e.port[0];
        i_dc_req_valid = e.port[1];
        force_err      = e.err;
        stall_ar       = e.stall_ar;
        w_delay        = e.w_delay;
        while (done != 2'b11 && cyc < 5000) begin
            @(posedge i_clk);
            cyc++;
            if (o_axi.ar_valid) begin
                ax = o_axi.ar;
            end else if (o_axi.aw_valid) begin
                ax = o_axi.aw;
            end
            take = {i_ic_req_valid && o_ic_req_ready, i_dc_req_valid && o_dc_req_ready};
            rv   = {o_ic_resp_valid, o_dc_resp_valid};
            if ((rv & done) != 2'b00) begin
                $display("test %0d: response strobe on a port with no open request", k);
                errors++;
            end
            if (rv[1] && !done[1]) begin
                check_resp(k, "o_ic_resp", o_ic_resp,
                           (e.port == 2'd3) ? e.exp_ic : e.exp_data, e);
                first_ic = (done == 2'b00);
            end
            if (rv[0] && !done[0]) begin
                check_resp(k, "o_dc_resp", o_dc_resp, e.exp_data, e);
            end
            done = done | rv;
            @(negedge i_clk);
            i_ic_req_valid = i_ic_req_valid && !take[1];
            i_dc_req_valid = i_dc_req_valid && !take[0];
        end
        i_ic_req_valid = 1'b0;
        i_dc_req_valid = 1'b0;
        force_err      = 1'b0;
        stall_ar       = 1'b0;
        w_delay        = 4'd0;
        if (done != 2'b11) begin
            $display("test %0d: no response within 5000 cycles", k);
            errors++;
        end
        if (e.port == 2'd3) begin
            check_val(k, "first served is IC", !last_ic, first_ic);   // Tie goes to the other port
        end else begin
            check_val(k, e.wr ? "o_axi.aw.addr" : "o_axi.ar.addr", e.addr, ax.addr);
            check_val(k, e.wr ? "o_axi.aw.cache" : "o_axi.ar.cache",
                      e.cached ? 4'hf : 4'h0, ax.cache);
            check_val(k, e.wr ? "o_axi.aw.prot" : "o_axi.ar.prot",
                      e.port[0] ? 3'd4 : 3'd0, ax.prot);
            last_ic = e.port[0];
        end
        @(posedge i_clk);
        if (!(o_ic_req_ready && o_dc_req_ready)) begin
            $display("test %0d: request readies did not return high after the response", k);
            errors++;
        end
        $display("test %0d %s", k, (errors == errs0) ? "passed" : "failed");
    endtask

    initial begin
        int i;
        void'($urandom(32'hd568_0c99));
        errors         = 0;
        last_ic        = 1'b1;      // DC has priority after reset
        i_nrst         = 1'b0;
        i_ic_req       = '0;
        i_dc_req       = '0;
        i_ic_req_valid = 1'b0;
        i_dc_req_valid = 1'b0;
        force_err      = 1'b0;
        stall_ar       = 1'b0;
        w_delay        = 4'd0;
        for (i = 0; i < 64; i++) begin
            ref_mem[i] = {8{32'hc0de_0000 + i}};
        end
        // port, write, cached, line, slave error, AR stall, W delay
        add_entry(2'd3, 1'b0, 1'b1, 6'd3,  1'b0, 1'b0, 4'd0);   // Tie right after reset
        add_entry(2'd2, 1'b1, 1'b1, 6'd10, 1'b0, 1'b0, 4'd0);
        add_entry(2'd2, 0, 1'b1, 6'd10, 1'b0, 1'b0, 4'd0);      // Read back
        add_entry(2'd3, 1'b0, 1'b1, 6'd30, 1'b0, 1'b0, 4'd0);   // Tie after a DC win
        add_entry(2'd1, 1'b0, 1'b0, 6'd20, 1'b0, 1'b0, 4'd0);
        add_entry(2'd2, 1'b0, 1'b1, 6'd40, 1'b1, 1'b0, 4'd0);   // RRESP error
        add_entry(2'd2, 1'b1, 1'b1, 6'd41, 1'b1, 1'b0, 4'd0);   // BRESP error
        add_entry(2'd2, 1'b0, 1'b1, 6'd41, 1'b0, 1'b0, 4'd0);
        add_entry(2'd1, 1'b1, 1'b0, 6'd50, 1'b0, 1'b0, 4'd3);   // W ready late
        add_entry(2'd2, 1'b0, 1'b0, 6'd50, 1'b0, 1'b0, 4'd0);
        add_entry(2'd2, 1'b0, 1'b1, 6'd60, 1'b0, 1'b1, 4'd0);   // Only the watchdog ends this
        table_done = 1'b1;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;
        for (i = 0; i < table_q.size(); i++) begin
            run_entry(i);
        end
        $display("%0d tests run, %0d errors", table_q.size(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (table_done);
        repeat (table_q.size() * 5000) @(posedge i_clk);
        $display("Run stopped, tests did not finish within %0d cycles", table_q.size() * 5000);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== logic/l1_axi_bridge.sv ====
/* Top of the L1 to AXI4 bridge. IC and DC share one master port and
   only one single-beat transaction is outstanding at any time */
`timescale 1ns/1ps

module l1_axi_bridge import l1_axi_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    // Instruction cache
    input  l1_req_t  i_ic_req,
    input  logic     i_ic_req_valid,
    output logic     o_ic_req_ready,
    output l1_resp_t o_ic_resp,
    output logic     o_ic_resp_valid,
    // Data cache
    input  l1_req_t  i_dc_req,
    input  logic     i_dc_req_valid,
    output logic     o_dc_req_ready,
    output l1_resp_t o_dc_resp,
    output logic     o_dc_resp_valid,
    // AXI master
    output axi_m2s_t o_axi,
    input  axi_s2m_t i_axi
);

    l1_req_t  txn_req;
    logic     txn_req_valid;
    logic     txn_ready;
    l1_resp_t txn_resp;
    logic     txn_resp_valid;

    l1_req_arbiter u_arb (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_ic_req         (i_ic_req),
        .i_ic_req_valid   (i_ic_req_valid),
        .o_ic_req_ready   (o_ic_req_ready),
        .o_ic_resp        (o_ic_resp),
        .o_ic_resp_valid  (o_ic_resp_valid),
        .i_dc_req         (i_dc_req),
        .i_dc_req_valid   (i_dc_req_valid),
        .o_dc_req_ready   (o_dc_req_ready),
        .o_dc_resp        (o_dc_resp),
        .o_dc_resp_valid  (o_dc_resp_valid),
        .o_txn_req        (txn_req),
        .o_txn_req_valid  (txn_req_valid),
        .i_txn_ready      (txn_ready),
        .i_txn_resp       (txn_resp),
        .i_txn_resp_valid (txn_resp_valid)
    );

    axi_txn_fsm u_fsm (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req        (txn_req),
        .i_req_valid  (txn_req_valid),
        .o_ready      (txn_ready),
        .o_resp       (txn_resp),
        .o_resp_valid (txn_resp_valid),
        .o_axi        (o_axi),
        .i_axi        (i_axi)
    );

endmodule

// ==== logic/l1_req_arbiter.sv ====
/* Two-port round robin in front of a single-transaction machine. Grant is
   combinational; responses are steered to whichever port owns the open transaction */
`timescale 1ns/1ps

module l1_req_arbiter import l1_axi_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    // Instruction cache port
    input  l1_req_t  i_ic_req,
    input  logic     i_ic_req_valid,
    output logic     o_ic_req_ready,
    output l1_resp_t o_ic_resp,
    output logic     o_ic_resp_valid,
    // Data cache port
    input  l1_req_t  i_dc_req,
    input  logic     i_dc_req_valid,
    output logic     o_dc_req_ready,
    output l1_resp_t o_dc_resp,
    output logic     o_dc_resp_valid,
    // Toward the transaction machine
    output l1_req_t  o_txn_req,
    output logic     o_txn_req_valid,
    input  logic     i_txn_ready,
    input  l1_resp_t i_txn_resp,
    input  logic     i_txn_resp_valid
);

    l1_path_e last_path;    // Last winner, also owner while owner_valid
    logic     owner_valid;
    logic     sel_ic;
    logic     accept;

    // IC wins only if DC is absent or DC went last
    assign sel_ic = i_ic_req_valid && (!i_dc_req_valid || last_path == L1_PATH_DATA);

    assign o_txn_req_valid = i_ic_req_valid || i_dc_req_valid;
    assign accept          = o_txn_req_valid && i_txn_ready;

    // Loser sees ready low, an idle port sees it high
    assign o_ic_req_ready = i_txn_ready && (sel_ic || !i_dc_req_valid);
    assign o_dc_req_ready = i_txn_ready && !sel_ic;

    always_comb begin
        if (sel_ic) begin
            o_txn_req      = i_ic_req;
            o_txn_req.path = L1_PATH_INSTR;
        end else begin
            o_txn_req      = i_dc_req;
            o_txn_req.path = L1_PATH_DATA;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            last_path   <= L1_PATH_INSTR;   // So DC wins the first tie
            owner_valid <= 1'b0;
        end else begin
            if (accept) begin
                last_path   <= sel_ic ? L1_PATH_INSTR : L1_PATH_DATA;
                owner_valid <= 1'b1;
            end else if (i_txn_resp_valid) begin
                owner_valid <= 1'b0;
            end
        end
    end

    // Data fans out to both, only the strobe is steered
    assign o_ic_resp = i_txn_resp;
    assign o_dc_resp = i_txn_resp;

    assign o_ic_resp_valid = i_txn_resp_valid && owner_valid && (last_path == L1_PATH_INSTR);
    assign o_dc_resp_valid = i_txn_resp_valid && owner_valid && (last_path == L1_PATH_DATA);

    // Machine must not answer a transaction this arbiter never handed over
    a_resp_has_owner: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_txn_resp_valid |-> owner_valid
    ) else $error("response strobe with no owning port");

endmodule

// ==== sources.f ====
common/l1_axi_pkg.sv
logic/l1_req_arbiter.sv
axi_master/axi_txn_fsm.sv
logic/l1_axi_bridge.sv
dv/axi_slave_model.sv
dv/tb_l1_axi_bridge.sv
